// ==== Makefile ====
# Verilator build and run for the Chitchat loopback testbench

VERILATOR ?= verilator
TOP       ?= chitchat_link_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) include/chitchat_cfg.svh sim/chitchat_patterns.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/chitchat_link.sv ====
// Chitchat loopback top level joining transmitter and receiver
`timescale 1ns/100ps

module chitchat_link #(
  parameter logic [31:0] REV_ID        = 32'h0,
  parameter logic [2:0]  GATEWARE_TYPE = 3'd0
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      tx_transmit_en,
  input  chitchat_pkg::cc_loc_t     tx_location,
  input  chitchat_pkg::cc_data_t    tx_data0,
  input  chitchat_pkg::cc_data_t    tx_data1,
  input  chitchat_pkg::cc_extra_t   tx_extra_data,
  output logic                      tx_send,
  output chitchat_pkg::cc_fcnt_t    local_frame_counter,
  output chitchat_pkg::cc_payload_t payload,
  output logic                      rx_valid,
  output chitchat_pkg::cc_extra_t   rx_extra_data,
  output logic                      rx_extra_valid,
  output logic                      rx_crc_err,
  output logic                      link_up
);

  // Serial line from TX to RX
  chitchat_pkg::cc_line_t line;

  // Received frame counter returned to the transmitter
  chitchat_pkg::cc_fcnt_t loopback_fcnt;

  assign loopback_fcnt = payload.frame_counter;

  chitchat_tx #(
    .REV_ID        (REV_ID),
    .GATEWARE_TYPE (GATEWARE_TYPE)
  ) tx0 (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .tx_transmit_en            (tx_transmit_en),
    .tx_location               (tx_location),
    .tx_data0                  (tx_data0),
    .tx_data1                  (tx_data1),
    .tx_extra_data             (tx_extra_data),
    .tx_loopback_frame_counter (loopback_fcnt),
    .tx_send                   (tx_send),
    .local_frame_counter       (local_frame_counter),
    .line                      (line)
  );

  chitchat_rx rx0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .line           (line),
    .payload        (payload),
    .rx_valid       (rx_valid),
    .rx_extra_data  (rx_extra_data),
    .rx_extra_valid (rx_extra_valid),
    .rx_crc_err     (rx_crc_err),
    .link_up        (link_up)
  );

endmodule

// ==== design/chitchat_pkg.sv ====
// Chitchat field types, line and payload structs, receiver FSM state enum
package chitchat_pkg;

  // Field widths
  typedef logic [15:0]  cc_word_t;
  typedef logic [2:0]   cc_loc_t;
  typedef logic [2:0]   cc_gw_t;
  typedef logic [31:0]  cc_data_t;
  typedef logic [15:0]  cc_fcnt_t;
  typedef logic [255:0] cc_extra_t;

  // One line word per clock
  // k[0] marks a comma in the low byte, k[1] is never set
  typedef struct packed {
    cc_word_t   d;
    logic [1:0] k;
  } cc_line_t;

  // Fields decoded from the last good frame
  typedef struct packed {
    cc_loc_t  location;
    cc_gw_t   gateware_type;
    cc_data_t rev_id;
    cc_data_t data0;
    cc_data_t data1;
    cc_fcnt_t frame_counter;
    cc_fcnt_t loopback_frame_counter;
  } cc_payload_t;

  // Receiver FSM
  // HUNT waits for a comma, COLLECT gathers the frame body,
  // CHECK sees the CRC word
  typedef enum logic [1:0] {
    HUNT,
    COLLECT,
    CHECK
  } cc_rx_state_e;

endpackage

// ==== design/chitchat_rx.sv ====
// Chitchat receiver: comma alignment, frame capture, CRC/protocol check, extra data, link state
`timescale 1ns/100ps
`include "chitchat_cfg.svh"

module chitchat_rx (
  input  logic                      clk,
  input  logic                      rst_n,
  input  chitchat_pkg::cc_line_t    line,
  output chitchat_pkg::cc_payload_t payload,
  output logic                      rx_valid,
  output chitchat_pkg::cc_extra_t   rx_extra_data,
  output logic                      rx_extra_valid,
  output logic                      rx_crc_err,
  output logic                      link_up
);

  localparam int TMO_W = $clog2(`CC_LINK_TIMEOUT + 1);
  localparam int RUN_W = $clog2(`CC_LINK_UP_CNT + 1);

  // ----------------------------------------------------------------------
  // Alignment and capture
  // ----------------------------------------------------------------------

  chitchat_pkg::cc_rx_state_e state;
  logic [3:0]                 word_cnt;
  logic                       comma;
  logic                       check;

  assign comma = line.k[0] && (line.d[7:0] == `CC_K28_5);
  assign check = (state == chitchat_pkg::CHECK);

  // HUNT takes word 0, COLLECT words 1..10, CHECK the CRC word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= chitchat_pkg::HUNT;
      word_cnt <= 4'd0;
    end else begin
      case (state)
        chitchat_pkg::HUNT: begin
          if (comma) begin
            state    <= chitchat_pkg::COLLECT;
            word_cnt <= 4'd1;
          end
        end
        chitchat_pkg::COLLECT: begin
          // A comma inside the body realigns to the new frame
          if (comma) begin
            word_cnt <= 4'd1;
          end else if (word_cnt == 4'(`CC_WORD_FRAME_CNT - 1)) begin
            state <= chitchat_pkg::CHECK;
          end else begin
            word_cnt <= word_cnt + 4'd1;
          end
        end
        chitchat_pkg::CHECK: begin
          state <= chitchat_pkg::HUNT;
        end
        default: begin
          state <= chitchat_pkg::HUNT;
        end
      endcase
    end
  end

  // Last 11 line words, oldest at index 10
  // In CHECK this is words 0..10 of the frame
  chitchat_pkg::cc_word_t [`CC_WORD_FRAME_CNT-1:0] frame_sr;

  always_ff @(posedge clk) begin
    frame_sr <= {frame_sr[`CC_WORD_FRAME_CNT-2:0], line.d};
  end

  // ----------------------------------------------------------------------
  // Frame check
  // ----------------------------------------------------------------------

  chitchat_pkg::cc_word_t crc_rx;
  logic                   crc_ok;
  logic                   proto_ok;
  logic                   frame_good;

  crc16 crc16_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (line.d),
    .zero  (comma),
    .crc   (crc_rx)
  );

  // Local CRC covers words 0..10 while word 11 is on the line
  assign crc_ok     = (line.d == crc_rx) && (line.k == 2'b00);
  assign proto_ok   = (frame_sr[10][15:12] == `CC_PROTOCOL_CAT) &&
                      (frame_sr[10][11:8] == `CC_PROTOCOL_VER);
  assign frame_good = crc_ok && proto_ok;

  // ----------------------------------------------------------------------
  // Payload and extra-data reassembly
  // ----------------------------------------------------------------------

  logic [3:0] slice;
  logic [3:0] seq_cnt;
  logic       fcnt_step;
  logic       seq_ok;

  // Slice index from the frame counter word
  assign slice     = frame_sr[2][3:0];
  assign fcnt_step = (frame_sr[2] == payload.frame_counter + 16'd1);

  // seq_cnt holds how many slices of the current block arrived in order
  assign seq_ok = (slice == 4'd0) || ((seq_cnt == slice) && fcnt_step);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid       <= 1'b0;
      rx_crc_err     <= 1'b0;
      rx_extra_valid <= 1'b0;
      payload        <= '0;
      seq_cnt        <= 4'd0;
    end else begin
      rx_valid       <= check && frame_good;
      rx_crc_err     <= check && !frame_good;
      rx_extra_valid <= check && frame_good && (slice == 4'hF) && seq_ok;
      if (check) begin
        if (frame_good) begin
          // Word 1 is {gateware type, location, reserved}
          payload <= '{location:               frame_sr[9][12:10],
                       gateware_type:          frame_sr[9][15:13],
                       rev_id:                 {frame_sr[8], frame_sr[7]},
                       data0:                  {frame_sr[6], frame_sr[5]},
                       data1:                  {frame_sr[4], frame_sr[3]},
                       frame_counter:          frame_sr[2],
                       loopback_frame_counter: frame_sr[1]};
          // Slice 15 wraps the count back to zero
          seq_cnt <= seq_ok ? slice + 4'd1 : 4'd0;
        end else begin
          seq_cnt <= 4'd0;
        end
      end
    end
  end

  // Block buffer, one 16-bit slice per good frame
  always_ff @(posedge clk) begin
    if (check && frame_good) begin
      rx_extra_data[{slice, 4'd0} +: 16] <= frame_sr[0];
    end
  end

  // ----------------------------------------------------------------------
  // Link state
  // ----------------------------------------------------------------------

  logic [RUN_W-1:0] good_run;
  logic [TMO_W-1:0] idle_cnt;
  logic             timeout;

  assign timeout = (idle_cnt == TMO_W'(`CC_LINK_TIMEOUT));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_cnt <= '0;
      good_run <= '0;
      link_up  <= 1'b0;
    end else begin
      // Clocks since the last comma, saturating
      if (comma) begin
        idle_cnt <= '0;
      end else if (!timeout) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (timeout) begin
        good_run <= '0;
        link_up  <= 1'b0;
      end else if (check) begin
        if (frame_good) begin
          if (good_run != RUN_W'(`CC_LINK_UP_CNT)) begin
            good_run <= good_run + 1'b1;
          end
          // Up together with the rx_valid of the N-th good frame
          if (good_run >= RUN_W'(`CC_LINK_UP_CNT - 1)) begin
            link_up <= 1'b1;
          end
        end else begin
          good_run <= '0;
          link_up  <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== design/chitchat_tx.sv ====
// Chitchat transmitter: frame timing, frame shift register, extra-data slices, CRC insertion
`timescale 1ns/100ps
`include "chitchat_cfg.svh"

module chitchat_tx #(
  parameter logic [31:0] REV_ID        = 32'h0,
  parameter logic [2:0]  GATEWARE_TYPE = 3'd0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    tx_transmit_en,
  input  chitchat_pkg::cc_loc_t   tx_location,
  input  chitchat_pkg::cc_data_t  tx_data0,
  input  chitchat_pkg::cc_data_t  tx_data1,
  input  chitchat_pkg::cc_extra_t tx_extra_data,
  input  chitchat_pkg::cc_fcnt_t  tx_loopback_frame_counter,
  output logic                    tx_send,
  output chitchat_pkg::cc_fcnt_t  local_frame_counter,
  output chitchat_pkg::cc_line_t  line
);

  localparam int FRAME_BITS = (`CC_WORD_FRAME_CNT + 1) * 16;

  // ----------------------------------------------------------------------
  // Frame timing
  // ----------------------------------------------------------------------

  logic [3:0] word_cnt;
  logic       advance;
  logic       start;
  logic       sync;
  logic       sync_r;
  logic       last;
  logic       last_r;
  logic       crc_time;

  // Keep counting to the end of a started frame even after enable drops
  assign advance = tx_transmit_en || (word_cnt != 4'd0);

  // start    frame load, one pulse per 12 clocks
  // sync     word 0 at the shift register head, CRC restart
  // sync_r   word 0 on the line, comma flag
  // crc_time word 11 at the head, CRC of words 0..10 ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= 4'd0;
      start    <= 1'b0;
      sync     <= 1'b0;
      sync_r   <= 1'b0;
      last     <= 1'b0;
      last_r   <= 1'b0;
      crc_time <= 1'b0;
    end else begin
      word_cnt <= (word_cnt == 4'(`CC_WORD_FRAME_CNT)) ? 4'd0 : word_cnt + 4'(advance);
      start    <= (word_cnt == 4'd1);
      sync     <= start;
      sync_r   <= sync;
      last     <= (word_cnt == 4'(`CC_WORD_FRAME_CNT));
      last_r   <= last;
      crc_time <= last_r;
    end
  end

  // Local frame counter, sampled into the frame before it steps
  chitchat_pkg::cc_fcnt_t fcnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fcnt <= '0;
    end else begin
      fcnt <= fcnt + 16'(start);
    end
  end

  // ----------------------------------------------------------------------
  // Extra data
  // ----------------------------------------------------------------------

  chitchat_pkg::cc_extra_t extra_snap;
  chitchat_pkg::cc_word_t  extra_word;
  logic [3:0]              slice;

  // Frame n carries slice n mod 16
  assign slice = fcnt[3:0];

  // Slice 0 comes straight from the input, the rest from the snapshot
  assign extra_word = (slice == 4'd0) ? tx_extra_data[15:0] : extra_snap[{slice, 4'd0} +: 16];

  always_ff @(posedge clk) begin
    if (start && (slice == 4'd0)) begin
      extra_snap <= tx_extra_data;
    end
  end

  // ----------------------------------------------------------------------
  // Frame shift register
  // ----------------------------------------------------------------------

  logic [FRAME_BITS-1:0] frame;

  // Parallel load at start, then one word out per clock
  // 32-bit fields go out high word first
  always_ff @(posedge clk) begin
    if (start) begin
      frame <= {`CC_PROTOCOL_CAT, `CC_PROTOCOL_VER, `CC_K28_5,
                GATEWARE_TYPE, tx_location, 10'd0,
                REV_ID,
                tx_data0,
                tx_data1,
                fcnt,
                tx_loopback_frame_counter,
                extra_word,
                16'd0};
    end else begin
      frame <= {frame[FRAME_BITS-17:0], 16'd0};
    end
  end

  // ----------------------------------------------------------------------
  // CRC and line output
  // ----------------------------------------------------------------------

  chitchat_pkg::cc_word_t head_word;
  chitchat_pkg::cc_word_t crc_tx;
  chitchat_pkg::cc_word_t line_d;

  assign head_word = frame[FRAME_BITS-1 -: 16];

  crc16 crc16_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (head_word),
    .zero  (sync),
    .crc   (crc_tx)
  );

  // Zero pad of word 11 replaced by the CRC
  always_ff @(posedge clk) begin
    line_d <= crc_time ? crc_tx : head_word;
  end

  assign line                = '{d: line_d, k: {1'b0, sync_r}};
  assign tx_send             = start;
  assign local_frame_counter = fcnt;

endmodule

// ==== design/crc16.sv ====
// CRC-16 generator, polynomial 0x1021, init 0, MSB first, one word per clock
`timescale 1ns/100ps

module crc16 (
  input  logic                   clk,
  input  logic                   rst_n,
  input  chitchat_pkg::cc_word_t din,
  input  logic                   zero,
  output chitchat_pkg::cc_word_t crc
);

  localparam logic [15:0] POLY = 16'h1021;

  // Fold 16 data bits into the CRC, MSB first
  function automatic chitchat_pkg::cc_word_t fold(input chitchat_pkg::cc_word_t c_in,
                                                  input chitchat_pkg::cc_word_t d);
    chitchat_pkg::cc_word_t c;
    logic                   fb;
    c = c_in;
    for (int i = 15; i >= 0; i--) begin
      fb = c[15] ^ d[i];
      c  = {c[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
    end
    return c;
  endfunction

  // Restart from zero on the first word of a frame
  chitchat_pkg::cc_word_t seed;

  assign seed = zero ? '0 : crc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      crc <= '0;
    end else begin
      crc <= fold(seed, din);
    end
  end

endmodule

// ==== include/chitchat_cfg.svh ====
// Chitchat frame length, comma code, protocol identity and link-state constants
`ifndef CHITCHAT_CFG_SVH
`define CHITCHAT_CFG_SVH

// ----------------------------------------------------------------------
// Frame format
// ----------------------------------------------------------------------

// Index of the last word in a frame (12 words per frame)
`define CC_WORD_FRAME_CNT 11

// K28.5 comma, carried in the low byte of word 0
`define CC_K28_5 8'hBC

// Protocol identity in the high byte of word 0
`define CC_PROTOCOL_CAT 4'h2
`define CC_PROTOCOL_VER 4'h1

// ----------------------------------------------------------------------
// Link state
// ----------------------------------------------------------------------

// Consecutive good frames needed before link up
`define CC_LINK_UP_CNT 4

// Clocks without a comma before link down
`define CC_LINK_TIMEOUT 48

`endif

// ==== sim/chitchat_link_props.sv ====
// Concurrent assertions on frame period, comma placement, CRC health and link stability
`timescale 1ns/100ps
`include "chitchat_cfg.svh"

module chitchat_link_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   tx_transmit_en,
  input logic                   tx_send,
  input chitchat_pkg::cc_line_t line,
  input logic                   rx_crc_err,
  input logic                   link_up
);

  // Next frame start 12 clocks later when enable holds through the frame
  a_send_period: assert property (@(posedge clk) disable iff (!rst_n)
    tx_send ##1 tx_transmit_en [*10] |-> ##2 tx_send)
    else $error("tx_send period broken");

  // No second start inside a frame
  a_send_gap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_send |=> !tx_send [*`CC_WORD_FRAME_CNT])
    else $error("tx_send repeated inside a frame");

  // k flag only on word 0 with the comma byte
  a_comma: assert property (@(posedge clk) disable iff (!rst_n)
    (line.k != 2'b00) |-> (line.k == 2'b01) && (line.d[7:0] == `CC_K28_5))
    else $error("k flag without comma byte");

  // Loopback cannot corrupt a frame
  a_no_crc_err: assert property (@(posedge clk) disable iff (!rst_n) !rx_crc_err)
    else $error("receiver flagged a bad frame");

  // Link only drops after the transmitter stops
  a_link_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(link_up) |-> !tx_transmit_en)
    else $error("link dropped while transmitting");

endmodule

bind chitchat_link chitchat_link_props props0 (
  .clk            (clk),
  .rst_n          (rst_n),
  .tx_transmit_en (tx_transmit_en),
  .tx_send        (tx_send),
  .line           (line),
  .rx_crc_err     (rx_crc_err),
  .link_up        (link_up)
);

// ==== sim/chitchat_link_tb.sv ====
// Chitchat loopback testbench with clock, reset, pattern stimulus, checks and watchdog
`timescale 1ns/100ps
`include "chitchat_cfg.svh"

module chitchat_link_tb;

  localparam logic [31:0] REV_ID     = 32'h1234ABCD;
  localparam logic [2:0]  GW_TYPE    = 3'd5;
  localparam int          FRAME_CLKS = `CC_WORD_FRAME_CNT + 1;

  logic                      clk;
  logic                      rst_n;
  logic                      tx_transmit_en;
  chitchat_pkg::cc_loc_t     tx_location;
  chitchat_pkg::cc_data_t    tx_data0;
  chitchat_pkg::cc_data_t    tx_data1;
  chitchat_pkg::cc_extra_t   tx_extra_data;
  logic                      tx_send;
  chitchat_pkg::cc_fcnt_t    local_frame_counter;
  chitchat_pkg::cc_payload_t payload;
  logic                      rx_valid;
  chitchat_pkg::cc_extra_t   rx_extra_data;
  logic                      rx_extra_valid;
  logic                      rx_crc_err;
  logic                      link_up;

  // Pattern table
  string                   pat_name[$];
  chitchat_pkg::cc_loc_t   pat_loc[$];
  chitchat_pkg::cc_data_t  pat_d0[$];
  chitchat_pkg::cc_data_t  pat_d1[$];
  chitchat_pkg::cc_extra_t pat_extra[$];
  int                      n_pat = 0;
  string                   test_name = "reset";
  logic                    settled = 1'b0;

  chitchat_link #(.REV_ID(REV_ID), .GATEWARE_TYPE(GW_TYPE)) dut0 (.*);

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------------------

  task automatic fail_run(input string what);
    $display("error: %0s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string field, input logic [255:0] exp,
                             input logic [255:0] act);
    assert (act == exp) else begin
      $display("mismatch %0s %0s expected %h actual %h", test_name, field, exp, act);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
    end
  endtask

  // Comment lines start with a lone # token
  task automatic load_patterns();
    int                        fd;
    int                        code;
    int                        ch;
    logic [255:0]              tok;
    chitchat_pkg::cc_loc_t     loc;
    chitchat_pkg::cc_data_t    d0;
    chitchat_pkg::cc_data_t    d1;
    chitchat_pkg::cc_extra_t   ex;
    fd = $fopen("sim/chitchat_patterns.txt", "r");
    if (fd == 0) fail_run("cannot open the pattern file");
    while (!$feof(fd)) begin
      tok  = '0;
      code = $fscanf(fd, "%s", tok);
      if (code == 1 && tok == 256'("#")) begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else if (code == 1) begin
        code = $fscanf(fd, "%h %h %h %h", loc, d0, d1, ex);
        if (code != 4) fail_run("malformed line in the pattern file");
        pat_name.push_back($sformatf("%0s", tok));
        pat_loc.push_back(loc);
        pat_d0.push_back(d0);
        pat_d1.push_back(d1);
        pat_extra.push_back(ex);
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Sequencing helpers sample outputs on the falling edge
  // ----------------------------------------------------------------------

  task automatic wait_extra_valid();
    do @(negedge clk); while (!rx_extra_valid);
  endtask

  // Link up needs at least CC_LINK_UP_CNT frames sent
  task automatic wait_link_up();
    int sends;
    sends = 0;
    do begin
      @(negedge clk);
      if (tx_send) sends++;
    end while (!link_up);
    assert (sends >= `CC_LINK_UP_CNT) else
      fail_run($sformatf("link came up after only %0d frames were sent", sends));
  endtask

  task automatic apply_pattern(input int i);
    @(posedge clk);
    tx_location   <= pat_loc[i];
    tx_data0      <= pat_d0[i];
    tx_data1      <= pat_d1[i];
    tx_extra_data <= pat_extra[i];
    test_name     = pat_name[i];
    settled       = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Monitors
  // ----------------------------------------------------------------------

  // Payload fields against the active pattern once settled
  always @(negedge clk) begin
    if (rst_n && rx_valid && settled) begin
      check_value("location", 256'(tx_location), 256'(payload.location));
      check_value("gateware_type", 256'(GW_TYPE), 256'(payload.gateware_type));
      check_value("rev_id", 256'(REV_ID), 256'(payload.rev_id));
      check_value("data0", 256'(tx_data0), 256'(payload.data0));
      check_value("data1", 256'(tx_data1), 256'(payload.data1));
    end
  end

  // Local counter steps once per frame sent, starting from zero
  chitchat_pkg::cc_fcnt_t sent_cnt = '0;

  always @(negedge clk) begin
    if (rst_n) begin
      check_value("local_frame_counter", 256'(sent_cnt), 256'(local_frame_counter));
      if (tx_send) sent_cnt = sent_cnt + 16'd1;
    end
  end

  // Frame counters step by one and loopback echoes an earlier counter
  bit                     seen[int];
  bit                     have_prev = 1'b0;
  chitchat_pkg::cc_fcnt_t prev_fcnt;
  chitchat_pkg::cc_fcnt_t prev_lb = '0;

  initial seen[0] = 1'b1;

  always @(negedge clk) begin
    if (rst_n && rx_valid) begin
      if (have_prev) begin
        check_value("frame_counter", 256'(prev_fcnt + 16'd1), 256'(payload.frame_counter));
      end
      assert (seen.exists(int'(payload.loopback_frame_counter))) else
        fail_run("loopback counter was never reported by the receiver");
      assert (payload.loopback_frame_counter >= prev_lb) else
        fail_run("loopback counter went backwards");
      seen[int'(payload.frame_counter)] = 1'b1;
      prev_fcnt = payload.frame_counter;
      prev_lb   = payload.loopback_frame_counter;
      have_prev = 1'b1;
    end
  end

  // Up to 40 frames per pattern plus two patterns of margin for the link tests
  initial begin
    wait (n_pat > 0);
    repeat ((n_pat + 2) * 40 * FRAME_CLKS) @(posedge clk);
    fail_run("run timed out waiting for the DUT");
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int since_off;
    clk            = 1'b0;
    rst_n          = 1'b0;
    tx_transmit_en = 1'b0;
    tx_location    = '0;
    tx_data0       = '0;
    tx_data1       = '0;
    tx_extra_data  = '0;
    load_patterns();
    if (pat_name.size() == 0) fail_run("the pattern file holds no patterns");
    n_pat = pat_name.size();

    repeat (5) @(posedge clk);
    rst_n          <= 1'b1;
    tx_transmit_en <= 1'b1;
    apply_pattern(0);
    test_name = "link_up";
    wait_link_up();

    // Each pattern starts right after an extra-data pulse
    for (int i = 0; i < n_pat; i++) begin
      if (i > 0) apply_pattern(i);
      test_name = pat_name[i];
      // First pulse may still carry the previous block
      wait_extra_valid();
      @(posedge clk);
      settled = 1'b1;
      wait_extra_valid();
      check_value("extra_data", pat_extra[i], rx_extra_data);
    end

    // Link loss after the transmitter stops
    // Disable lands inside a started frame so no further start may follow
    test_name = "link_loss";
    @(posedge clk);
    tx_transmit_en <= 1'b0;
    since_off = 0;
    while (link_up) begin
      @(negedge clk);
      since_off++;
      assert (!tx_send) else fail_run("tx_send pulsed after disable");
      assert (since_off <= `CC_LINK_TIMEOUT + FRAME_CLKS) else
        fail_run("link_up stayed high after frames stopped");
    end
    repeat (2 * FRAME_CLKS) begin
      @(negedge clk);
      assert (!tx_send) else fail_run("tx_send pulsed while disabled");
    end

    // Link comes back once frames resume
    test_name = "link_restore";
    @(posedge clk);
    tx_transmit_en <= 1'b1;
    wait_link_up();
    repeat (2 * FRAME_CLKS) @(negedge clk);

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== sim/chitchat_patterns.txt ====
# name location data0 data1 extra (hex, 64 digits)
# extra slice k is bits 16k+15 down to 16k
p_zero 0 00000000 00000000 0000000000000000000000000000000000000000000000000000000000000000
p_ones 7 ffffffff ffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
p_count 1 01234567 89abcdef 0123456789abcdef1032547698badcfe0011223344556677f0e1d2c3b4a59687
p_alt 2 aaaa5555 5555aaaa a5a55a5aa5a55a5a5a5aa5a55a5aa5a5c3c33c3cc3c33c3c0ff0f00f0ff0f00f
p_walk 3 00000001 80000000 0001000200040008001000200040008001000200040008001000200040008000
p_mixed 4 deadbeef cafef00d 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
p_slices 5 13579bdf 2468ace0 000f000e000d000c000b000a00090008000700060005000400030002000100ff
p_tail 6 7fffffff 00000080 8000000000000001fedcba987654321000000000000000017ffe8001deadc0de

// ==== vlog.f ====
+incdir+include
design/chitchat_pkg.sv
design/crc16.sv
design/chitchat_tx.sv
design/chitchat_rx.sv
design/chitchat_link.sv
sim/chitchat_link_props.sv
sim/chitchat_link_tb.sv
